// File: Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/mem_ifs.sv
      - source/mem_issue_stage.sv
      - source/apb_master_fsm.sv
      - source/mem_stage.sv
      - source/mem_subsys.sv
  - target: test
    files:
      - tests/mem_subsys_asserts.sv
      - tests/mem_subsys_tb.sv

// File: files.f
+incdir+source
source/mem_pkg.sv
source/mem_ifs.sv
source/mem_issue_stage.sv
source/apb_master_fsm.sv
source/mem_stage.sv
source/mem_subsys.sv
tests/mem_subsys_asserts.sv
tests/mem_subsys_tb.sv

// File: source/apb_master_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module apb_master_fsm import mem_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    mem_req_if.completer req_bus,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output addr_t      paddr,
    output word_t      pwdata,
    output strb_t      pstrb,
    input  wire word_t prdata,
    input  wire logic  pready,
    input  wire logic  pslverr
);

    apb_state_t state;
    apb_state_t state_next;
    logic       start;    // new request taken in idle

    assign start = state == st_idle && req_bus.req;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_bus.req) begin
                    state_next = st_setup;
                end
            end
            st_setup: state_next = st_access;
            st_access: begin
                if (pready) begin
                    state_next = st_idle;   // wait states end here
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // transfer fields held for setup and every access cycle
    always_ff @(posedge clk) begin
        if (start) begin
            pwrite <= req_bus.write;
            paddr  <= req_bus.addr & ~addr_t'(3);   // word aligned on the bus
            pwdata <= req_bus.wdata;
            pstrb  <= req_bus.strb;
        end
    end

    assign psel    = state != st_idle;
    assign penable = state == st_access;

    assign req_bus.done  = state == st_access && pready;
    assign req_bus.rdata = prdata;
    assign req_bus.err   = pslverr;

endmodule

`default_nettype wire

// File: source/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// data word width, also the bus width toward memory
`define MEM_DATA_W 32

// byte address width
`define MEM_ADDR_W 32

// gpr index width
`define MEM_REG_W 5

`endif

// File: source/mem_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// issue stage to memory stage, valid/allowin handshake
interface stage_if import mem_pkg::*; ();
    logic     valid;
    logic     allowin;
    mem_op_t  op;
    addr_t    addr;       // byte address, or alu result for non-memory ops
    word_t    rt_value;   // old rt for lwl/lwr merge
    word_t    rdata;      // raw bus word, zero when no access
    reg_idx_t dest;
    logic     gr_we;
    logic     ex_addr;
    logic     ex_bus;
    addr_t    pc;

    modport producer (
        output valid, op, addr, rt_value, rdata, dest, gr_we, ex_addr, ex_bus, pc,
        input  allowin
    );
    modport consumer (
        input  valid, op, addr, rt_value, rdata, dest, gr_we, ex_addr, ex_bus, pc,
        output allowin
    );
endinterface

// one bus request at a time, held until done
interface mem_req_if import mem_pkg::*; ();
    logic  req;
    logic  write;
    addr_t addr;
    word_t wdata;
    strb_t strb;
    logic  done;    // single cycle pulse
    word_t rdata;
    logic  err;

    modport requester (output req, write, addr, wdata, strb, input done, rdata, err);
    modport completer (input req, write, addr, wdata, strb, output done, rdata, err);
endinterface

`default_nettype wire

// File: source/mem_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_issue_stage import mem_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     in_valid,
    output logic          in_allowin,
    input  wire mem_op_t  op,
    input  wire addr_t    addr,
    input  wire word_t    rt_value,
    input  wire reg_idx_t dest,
    input  wire logic     gr_we,
    input  wire addr_t    pc,
    mem_req_if.requester  req_bus,
    stage_if.producer     to_ms
);

    logic       is_valid;
    logic       is_waiting;   // bus transfer still outstanding
    mem_op_t    is_op;
    addr_t      is_addr;
    word_t      is_rt;
    reg_idx_t   is_dest;
    logic       is_gr_we;
    addr_t      is_pc;
    logic       is_ex_addr;
    logic       is_ex_bus;
    word_t      is_rdata;

    logic       ready_go;
    logic       in_fire;
    logic       mis_half;
    logic       mis_word;
    logic       addr_err;     // misaligned incoming access
    logic       is_store;
    logic [1:0] lane;

    assign mis_half = addr[0];
    assign mis_word = addr[1:0] != 2'b00;

    always_comb begin
        case (op)
            op_lh, op_lhu, op_sh: addr_err = mis_half;
            op_lw, op_sw:         addr_err = mis_word;
            default:              addr_err = 1'b0;
        endcase
    end

    assign ready_go   = !is_waiting;
    assign in_allowin = !is_valid || ready_go && to_ms.allowin;
    assign in_fire    = in_valid && in_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            is_valid <= 1'b0;
        end else if (in_allowin) begin
            is_valid <= in_valid;
        end
    end

    // a faulting op never reaches the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            is_waiting <= 1'b0;
        end else if (in_fire) begin
            is_waiting <= op != op_none && !addr_err;
        end else if (req_bus.done) begin
            is_waiting <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            is_op      <= op;
            is_addr    <= addr;
            is_rt      <= rt_value;
            is_dest    <= dest;
            is_gr_we   <= gr_we;
            is_pc      <= pc;
            is_ex_addr <= addr_err;
            is_ex_bus  <= 1'b0;
            is_rdata   <= '0;
        end else if (req_bus.done) begin
            is_rdata  <= req_bus.rdata;
            is_ex_bus <= req_bus.err;
        end
    end

    assign lane     = is_addr[1:0];
    assign is_store = is_op inside {op_sb, op_sh, op_sw, op_swl, op_swr};

    // byte lanes and data placement for stores, little endian
    always_comb begin
        req_bus.strb  = 4'b1111;   // loads and sw take the whole word
        req_bus.wdata = is_rt;
        case (is_op)
            op_sb: begin
                req_bus.strb  = 4'b0001 << lane;
                req_bus.wdata = {4{is_rt[7:0]}};
            end
            op_sh: begin
                req_bus.strb  = lane[1] ? 4'b1100 : 4'b0011;
                req_bus.wdata = {2{is_rt[15:0]}};
            end
            op_swl: begin
                req_bus.strb  = 4'b1111 >> ~lane;   // high bytes of rt go low
                req_bus.wdata = is_rt >> {~lane, 3'b000};
            end
            op_swr: begin
                req_bus.strb  = 4'b1111 << lane;
                req_bus.wdata = is_rt << {lane, 3'b000};
            end
            default: ;
        endcase
    end

    assign req_bus.req   = is_valid && is_waiting;
    assign req_bus.write = is_store;
    assign req_bus.addr  = is_addr;

    assign to_ms.valid    = is_valid && ready_go;
    assign to_ms.op       = is_op;
    assign to_ms.addr     = is_addr;
    assign to_ms.rt_value = is_rt;
    assign to_ms.rdata    = is_rdata;
    assign to_ms.dest     = is_dest;
    assign to_ms.gr_we    = is_gr_we;
    assign to_ms.ex_addr  = is_ex_addr;
    assign to_ms.ex_bus   = is_ex_bus;
    assign to_ms.pc       = is_pc;

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`MEM_DATA_W-1:0]   word_t;
    typedef logic [`MEM_ADDR_W-1:0]   addr_t;
    typedef logic [`MEM_DATA_W/8-1:0] strb_t;    // one bit per byte lane
    typedef logic [`MEM_REG_W-1:0]    reg_idx_t;

    // memory operation carried down from decode
    typedef enum logic [3:0] {
        op_none,    // alu op, result passes through
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr,
        op_sb,
        op_sh,
        op_sw,
        op_swl,
        op_swr
    } mem_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_setup,   // psel high, penable low
        st_access   // penable high until pready
    } apb_state_t;

endpackage

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mem_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    stage_if.consumer from_is,
    input  wire logic wb_allowin,
    output logic      wb_valid,
    output logic      wb_we,
    output reg_idx_t  wb_dest,
    output word_t     wb_data,
    output addr_t     wb_pc,
    output logic      wb_ex_addr,
    output logic      wb_ex_bus,
    output reg_idx_t  fwd_dest,
    output word_t     fwd_data
);

    logic       ms_valid;
    mem_op_t    ms_op;
    addr_t      ms_addr;
    word_t      ms_rt;
    word_t      ms_rdata;
    reg_idx_t   ms_dest;
    logic       ms_gr_we;
    logic       ms_ex_addr;
    logic       ms_ex_bus;
    addr_t      ms_pc;

    logic [1:0] lane;
    word_t      lane_word;    // addressed byte moved down to bit 0
    word_t      lwl_mask;     // rt bytes kept by lwl
    word_t      lwr_mask;     // rt bytes kept by lwr
    word_t      load_data;
    word_t      final_result;
    logic       is_load;

    // always ready to go, so only the writeback side can stall
    assign from_is.allowin = !ms_valid || wb_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (from_is.allowin) begin
            ms_valid <= from_is.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_is.valid && from_is.allowin) begin
            ms_op      <= from_is.op;
            ms_addr    <= from_is.addr;
            ms_rt      <= from_is.rt_value;
            ms_rdata   <= from_is.rdata;
            ms_dest    <= from_is.dest;
            ms_gr_we   <= from_is.gr_we;
            ms_ex_addr <= from_is.ex_addr;
            ms_ex_bus  <= from_is.ex_bus;
            ms_pc      <= from_is.pc;
        end
    end

    assign lane      = ms_addr[1:0];
    assign lane_word = ms_rdata >> {lane, 3'b000};
    assign lwl_mask  = ~(word_t'('1) << {~lane, 3'b000});
    assign lwr_mask  = ~(word_t'('1) >> {lane, 3'b000});

    always_comb begin
        case (ms_op)
            op_lb:   load_data = {{24{lane_word[7]}}, lane_word[7:0]};
            op_lbu:  load_data = {24'd0, lane_word[7:0]};
            op_lh:   load_data = {{16{lane_word[15]}}, lane_word[15:0]};
            op_lhu:  load_data = {16'd0, lane_word[15:0]};
            op_lwl:  load_data = (ms_rdata << {~lane, 3'b000}) | (ms_rt & lwl_mask);
            op_lwr:  load_data = lane_word | (ms_rt & lwr_mask);
            default: load_data = ms_rdata;   // lw
        endcase
    end

    assign is_load      = ms_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr};
    assign final_result = is_load ? load_data : ms_addr;

    assign wb_valid   = ms_valid;
    assign wb_we      = ms_gr_we && !ms_ex_addr && !ms_ex_bus;   // faults never write the rf
    assign wb_dest    = ms_dest;
    assign wb_data    = final_result;
    assign wb_pc      = ms_pc;
    assign wb_ex_addr = ms_ex_addr;
    assign wb_ex_bus  = ms_ex_bus;

    // bypass to decode, zero dest when nothing is written
    assign fwd_dest = (wb_valid && wb_we) ? ms_dest : '0;
    assign fwd_data = final_result;

endmodule

`default_nettype wire

// File: source/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys import mem_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    // from execute
    input  wire logic     in_valid,
    output logic          in_allowin,
    input  wire mem_op_t  op,
    input  wire addr_t    addr,
    input  wire word_t    rt_value,
    input  wire reg_idx_t dest,
    input  wire logic     gr_we,
    input  wire addr_t    pc,
    // to writeback
    input  wire logic     wb_allowin,
    output logic          wb_valid,
    output logic          wb_we,
    output reg_idx_t      wb_dest,
    output word_t         wb_data,
    output addr_t         wb_pc,
    output logic          wb_ex_addr,
    output logic          wb_ex_bus,
    output reg_idx_t      fwd_dest,
    output word_t         fwd_data,
    // apb data memory port
    output logic          psel,
    output logic          penable,
    output logic          pwrite,
    output addr_t         paddr,
    output word_t         pwdata,
    output strb_t         pstrb,
    input  wire word_t    prdata,
    input  wire logic     pready,
    input  wire logic     pslverr
);

    stage_if   stage_bus ();
    mem_req_if mem_req ();

    mem_issue_stage issue0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .op         (op),
        .addr       (addr),
        .rt_value   (rt_value),
        .dest       (dest),
        .gr_we      (gr_we),
        .pc         (pc),
        .req_bus    (mem_req.requester),
        .to_ms      (stage_bus.producer)
    );

    apb_master_fsm apb0 (
        .clk     (clk),
        .reset   (reset),
        .req_bus (mem_req.completer),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    mem_stage stage0 (
        .clk        (clk),
        .reset      (reset),
        .from_is    (stage_bus.consumer),
        .wb_allowin (wb_allowin),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc),
        .wb_ex_addr (wb_ex_addr),
        .wb_ex_bus  (wb_ex_bus),
        .fwd_dest   (fwd_dest),
        .fwd_data   (fwd_data)
    );

endmodule

`default_nettype wire

// File: tests/mem_subsys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_asserts import mem_pkg::*; (
    input wire logic     clk,
    input wire logic     reset,
    input wire logic     in_allowin,
    input wire logic     psel,
    input wire logic     penable,
    input wire logic     pwrite,
    input wire addr_t    paddr,
    input wire word_t    pwdata,
    input wire strb_t    pstrb,
    input wire logic     pready,
    input wire logic     wb_valid,
    input wire logic     wb_allowin,
    input wire logic     wb_we,
    input wire reg_idx_t wb_dest,
    input wire word_t    wb_data,
    input wire addr_t    wb_pc,
    input wire logic     wb_ex_addr,
    input wire logic     wb_ex_bus
);

    int unsigned fail_count = 0;   // watched from the testbench top

    // access phase only after a setup cycle
    penable_after_setup: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel && !penable))
        else begin fail_count++; $error("penable rose without a setup cycle"); end

    setup_then_access: assert property (@(posedge clk) disable iff (reset)
        psel && !penable |=> psel && penable)
        else begin fail_count++; $error("setup cycle not followed by an access cycle"); end

    // fields frozen from setup until pready
    apb_fields_hold: assert property (@(posedge clk) disable iff (reset)
        psel && (!penable || !pready) |=> psel && $stable(paddr) && $stable(pwrite)
            && $stable(pstrb) && $stable(pwdata))
        else begin fail_count++; $error("APB fields changed while a transfer waited"); end

    paddr_word_aligned: assert property (@(posedge clk) disable iff (reset)
        psel |-> paddr[1:0] == 2'b00)
        else begin fail_count++; $error("paddr is not word aligned"); end

    wb_hold: assert property (@(posedge clk) disable iff (reset)
        wb_valid && !wb_allowin |=> wb_valid && $stable(wb_we) && $stable(wb_dest)
            && $stable(wb_data) && $stable(wb_pc) && $stable(wb_ex_addr) && $stable(wb_ex_bus))
        else begin fail_count++; $error("writeback outputs moved while stalled"); end

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !psel && !penable && !wb_valid && in_allowin)
        else begin fail_count++; $error("outputs not idle after reset"); end

endmodule

`default_nettype wire

// File: tests/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb import mem_pkg::*; ();

    localparam int         num_instr  = 300;
    localparam int         timeout_ns = num_instr * 10 * 10;   // 10 cycles per instruction
    localparam logic [5:0] err_word   = 6'd63;                 // slave answers pslverr here

    typedef struct packed {
        logic     chk_data;   // faults leave wb_data undefined
        word_t    data;
        logic     we;
        reg_idx_t dest;
        addr_t    pc;
        logic     ex_addr;
        logic     ex_bus;
    } wb_exp_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        strb_t strb;
        word_t data;
    } bus_exp_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     in_valid;
    logic     in_allowin;
    mem_op_t  op;
    addr_t    addr;
    word_t    rt_value;
    reg_idx_t dest;
    logic     gr_we;
    addr_t    pc;
    logic     wb_allowin;
    logic     wb_valid;
    logic     wb_we;
    reg_idx_t wb_dest;
    word_t    wb_data;
    addr_t    wb_pc;
    logic     wb_ex_addr;
    logic     wb_ex_bus;
    reg_idx_t fwd_dest;
    word_t    fwd_data;
    logic     psel;
    logic     penable;
    logic     pwrite;
    addr_t    paddr;
    word_t    pwdata;
    strb_t    pstrb;
    word_t    prdata;
    logic     pready;
    logic     pslverr;

    integer   seed = 32'hdd4f;
    integer   slave_seed = 32'hdd4f;   // wait states drawn apart from the stimulus
    word_t    model_mem [64];          // contents held by the slave
    word_t    ref_mem [64];            // expected contents
    wb_exp_t  wb_q [$];
    bus_exp_t bus_q [$];
    int       wait_left;
    int       sent;
    logic     taken;

    mem_subsys dut0 (.*);

    bind mem_subsys mem_subsys_asserts chk0 (
        .clk(clk), .reset(reset), .in_allowin(in_allowin),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready),
        .wb_valid(wb_valid), .wb_allowin(wb_allowin), .wb_we(wb_we), .wb_dest(wb_dest),
        .wb_data(wb_data), .wb_pc(wb_pc), .wb_ex_addr(wb_ex_addr), .wb_ex_bus(wb_ex_bus)
    );

    always #5 clk = ~clk;

    function automatic word_t next_random();
        return $random(seed);
    endfunction

    function automatic word_t fill_word(int i);
        return {i[7:0] ^ 8'hc3, ~i[7:0], i[7:0] + 8'h5a, i[7:0]};
    endfunction

    function automatic logic is_load_op(mem_op_t o);
        return o inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr};
    endfunction

    function automatic logic misaligned(mem_op_t o, logic [1:0] ln);
        case (o)
            op_lh, op_lhu, op_sh: return ln[0];
            op_lw, op_sw:         return ln != 2'b00;
            default:              return 1'b0;
        endcase
    endfunction

    // little endian MIPS load rules applied byte by byte
    function automatic word_t load_expect(mem_op_t o, logic [1:0] ln, word_t m, word_t rt);
        word_t r;
        int    base;
        int    k;
        base = ln;
        r = rt;
        case (o)
            op_lb:  r = {{24{m[8*base+7]}}, m[8*base +: 8]};
            op_lbu: r = {24'd0, m[8*base +: 8]};
            op_lh:  r = {{16{m[8*base+15]}}, m[8*base +: 16]};
            op_lhu: r = {16'd0, m[8*base +: 16]};
            op_lw:  r = m;
            op_lwl: begin
                for (k = 0; k <= base; k++)
                    r[8*(3-base+k) +: 8] = m[8*k +: 8];   // top of rt from bytes 0..ln
            end
            op_lwr: begin
                for (k = base; k < 4; k++)
                    r[8*(k-base) +: 8] = m[8*k +: 8];
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic store_expect(input mem_op_t o, input logic [1:0] ln, input word_t rt,
                                output strb_t s, output word_t d);
        int base;
        int k;
        base = ln;
        s = '0;
        d = '0;
        case (o)
            op_sb: begin
                s[base] = 1'b1;
                d[8*base +: 8] = rt[7:0];
            end
            op_sh: begin
                for (k = base; k < base + 2; k++) begin
                    s[k] = 1'b1;
                    d[8*k +: 8] = rt[8*(k-base) +: 8];
                end
            end
            op_sw: begin
                s = '1;
                d = rt;
            end
            op_swl: begin
                for (k = 0; k <= base; k++) begin
                    s[k] = 1'b1;
                    d[8*k +: 8] = rt[8*(3-base+k) +: 8];
                end
            end
            op_swr: begin
                for (k = base; k < 4; k++) begin
                    s[k] = 1'b1;
                    d[8*k +: 8] = rt[8*(k-base) +: 8];
                end
            end
            default: ;
        endcase
    endtask

    task automatic fail_now(input string msg);
        $display("STATUS: FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic new_instr();
        word_t r;
        word_t r2;
        logic  store;
        r = next_random();
        op = mem_op_t'(r[3:0] % 4'd13);
        rt_value = next_random();
        r2 = next_random();
        dest = r2[4:0];
        pc = {r2[31:2], 2'b00};
        if (op == op_none)
            addr = next_random();
        else if (r[7:4] == 4'd0)
            addr = {24'd0, err_word, r[9:8]};   // hit the error word now and then
        else
            addr = {24'd0, 1'b0, r[14:10], r[9:8]};
        store = op != op_none && !is_load_op(op);
        gr_we = !store && (op != op_none || r[15]);
    endtask

    // reference model step for one accepted instruction
    task automatic accept_instr();
        wb_exp_t  e;
        bus_exp_t b;
        int       widx;
        int       k;
        logic     ex_a;
        logic     ex_b;
        strb_t    s;
        word_t    d;
        widx = addr[7:2];
        ex_a = misaligned(op, addr[1:0]);
        ex_b = op != op_none && !ex_a && addr[7:2] == err_word;
        store_expect(op, addr[1:0], rt_value, s, d);
        if (op != op_none && !ex_a) begin
            b.write = !is_load_op(op);
            b.addr  = {addr[31:2], 2'b00};
            b.strb  = b.write ? s : 4'b1111;
            b.data  = d;
            bus_q.push_back(b);
        end
        e.data = is_load_op(op) ? load_expect(op, addr[1:0], ref_mem[widx], rt_value) : addr;
        if (op != op_none && !is_load_op(op) && !ex_a && !ex_b) begin
            for (k = 0; k < 4; k++)
                if (s[k])
                    ref_mem[widx][8*k +: 8] = d[8*k +: 8];
        end
        e.chk_data = !ex_a && !ex_b;
        e.we       = gr_we && !ex_a && !ex_b;
        e.dest     = dest;
        e.pc       = pc;
        e.ex_addr  = ex_a;
        e.ex_bus   = ex_b;
        wb_q.push_back(e);
    endtask

    initial begin : stimulus
        word_t r;
        reset      = 1'b1;
        in_valid   = 1'b0;
        op         = op_none;
        addr       = '0;
        rt_value   = '0;
        dest       = '0;
        gr_we      = 1'b0;
        pc         = '0;
        wb_allowin = 1'b0;
        prdata     = '0;
        pready     = 1'b0;
        pslverr    = 1'b0;
        taken      = 1'b0;
        sent       = 0;
        wait_left  = 0;
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        while (sent < num_instr) begin
            @(negedge clk);
            r = next_random();
            wb_allowin = r[1:0] != 2'b00;   // stall about a quarter of the time
            if (!in_valid || taken) begin
                taken = 1'b0;
                in_valid = r[4:2] != 3'b000;
                if (in_valid)
                    new_instr();
            end
            @(posedge clk);
            if (in_valid && in_allowin) begin
                accept_instr();
                taken = 1'b1;
                sent++;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (wb_q.size() != 0) begin
            @(negedge clk);
            r = next_random();
            wb_allowin = r[0];
        end
        repeat (4) @(negedge clk);
        if (bus_q.size() != 0 || dut0.chk0.fail_count != 0) begin
            fail_now("bus transfers left unissued or a protocol assertion failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    // APB slave answering on the falling edge
    always @(negedge clk) begin : apb_slave
        bus_exp_t b;
        word_t    r;
        int       widx;
        int       k;
        if (reset) begin
            pready  = 1'b0;
            pslverr = 1'b0;
        end else if (psel && !penable) begin
            if (bus_q.size() == 0)
                fail_now("psel rose with no bus access expected");
            b = bus_q.pop_front();
            assert (paddr == b.addr)
                else fail_now($sformatf("mismatch at %0t: paddr is %h, expected %h",
                                        $time, paddr, b.addr));
            assert (pwrite == b.write)
                else fail_now($sformatf("mismatch at %0t: pwrite is %b, expected %b",
                                        $time, pwrite, b.write));
            assert (pstrb == b.strb)
                else fail_now($sformatf("mismatch at %0t: pstrb is %b, expected %b",
                                        $time, pstrb, b.strb));
            for (k = 0; k < 4; k++) begin
                if (b.write && b.strb[k]) begin
                    assert (pwdata[8*k +: 8] == b.data[8*k +: 8])
                        else fail_now($sformatf("mismatch at %0t: pwdata is %h, expected %h",
                                                $time, pwdata, b.data));
                end
            end
            r = $random(slave_seed);
            wait_left = r[1:0];
            pready  = 1'b0;
            pslverr = 1'b0;
        end else if (psel && penable && wait_left == 0) begin
            widx    = paddr[7:2];
            pready  = 1'b1;
            pslverr = paddr[7:2] == err_word;
            prdata  = model_mem[widx];
            if (pwrite && !pslverr)
                for (k = 0; k < 4; k++)
                    if (pstrb[k])
                        model_mem[widx][8*k +: 8] = pwdata[8*k +: 8];
        end else begin
            if (psel && penable)
                wait_left--;
            pready  = 1'b0;
            pslverr = 1'b0;
        end
    end

    always @(posedge clk) begin : wb_check
        wb_exp_t  e;
        reg_idx_t fwd_exp;
        if (!reset) begin
            assert (dut0.chk0.fail_count == 0)
                else fail_now("a bound protocol assertion failed");
            if (!wb_valid) begin
                assert (fwd_dest == reg_idx_t'(0))
                    else fail_now($sformatf("mismatch at %0t: fwd_dest is %0d, expected 0",
                                            $time, fwd_dest));
            end else begin
                if (wb_q.size() == 0)
                    fail_now("writeback appeared with no instruction outstanding");
                e = wb_q[0];
                fwd_exp = e.we ? e.dest : reg_idx_t'(0);   // nothing forwarded without a write
                assert (fwd_dest == fwd_exp)
                    else fail_now($sformatf("mismatch at %0t: fwd_dest is %0d, expected %0d",
                                            $time, fwd_dest, fwd_exp));
                if (e.chk_data) begin
                    assert (fwd_data == e.data)
                        else fail_now($sformatf("mismatch at %0t: fwd_data is %h, expected %h",
                                                $time, fwd_data, e.data));
                end
                if (wb_allowin) begin
                    e = wb_q.pop_front();
                    assert (wb_pc == e.pc)
                        else fail_now($sformatf("mismatch at %0t: wb_pc is %h, expected %h",
                                                $time, wb_pc, e.pc));
                    assert (wb_dest == e.dest)
                        else fail_now($sformatf("mismatch at %0t: wb_dest is %0d, expected %0d",
                                                $time, wb_dest, e.dest));
                    assert (wb_we == e.we)
                        else fail_now($sformatf("mismatch at %0t: wb_we is %b, expected %b",
                                                $time, wb_we, e.we));
                    assert (wb_ex_addr == e.ex_addr)
                        else fail_now($sformatf("mismatch at %0t: wb_ex_addr is %b, expected %b",
                                                $time, wb_ex_addr, e.ex_addr));
                    assert (wb_ex_bus == e.ex_bus)
                        else fail_now($sformatf("mismatch at %0t: wb_ex_bus is %b, expected %b",
                                                $time, wb_ex_bus, e.ex_bus));
                    if (e.chk_data) begin
                        assert (wb_data == e.data)
                            else fail_now($sformatf("mismatch at %0t: wb_data is %h, expected %h",
                                                    $time, wb_data, e.data));
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        fail_now($sformatf("timeout after %0d ns with %0d writebacks still pending",
                           timeout_ns, wb_q.size()));
    end

endmodule

`default_nettype wire
